//--- Makefile
# sources come straight from the file list
SRCS := $(shell cat verilog.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_cpu: verilog.f $(SRCS)
	verilator --binary --assert --top-module tb_cpu -f verilog.f

# the run passes only if the pass line shows up in the output
run: obj_dir/Vtb_cpu
	./obj_dir/Vtb_cpu | tee /dev/stderr | grep "TEST RESULT: PASS" > /dev/null

clean:
	rm -rf obj_dir

//--- alu32.sv
`timescale 1ns/100ps

module alu32 #(
  parameter int mem_addr_size = 10
) (
  input  cpu_pkg::opcode_t                  opcode,
  input  cpu_pkg::sub_op_t                  sub_op,
  input  logic [cpu_pkg::data_size-1:0]     read_data1,
  input  logic [cpu_pkg::data_size-1:0]     read_data2,
  input  logic [cpu_pkg::data_size-1:0]     imm,
  input  logic                              imm_reg_select,
  output logic [31:0]                       alu_result
);
  import cpu_pkg::*;

  logic [data_size-1:0] operand_b;
  logic [data_size-1:0] addr_sum;

  // second operand from immediate or register
  assign operand_b = imm_reg_select ? imm : read_data2;
  assign addr_sum  = read_data1 + operand_b;

  always_comb begin
    alu_result = '0;
    case (opcode)
      OP_ALU: begin
        case (sub_op)
          SUB_ADD:  alu_result = read_data1 + operand_b;
          SUB_SUB:  alu_result = read_data1 - operand_b;
          SUB_AND:  alu_result = read_data1 & operand_b;
          SUB_OR:   alu_result = read_data1 | operand_b;
          SUB_XOR:  alu_result = read_data1 ^ operand_b;
          SUB_SLLI: alu_result = read_data1 << operand_b[4:0];
          SUB_SRLI: alu_result = read_data1 >> operand_b[4:0];
          default:  alu_result = '0;
        endcase
      end
      OP_ADDI: alu_result = read_data1 + operand_b;
      OP_ORI:  alu_result = read_data1 | operand_b;
      OP_MOVI: alu_result = operand_b;
      // word address, upper bits stay zero
      OP_LWI, OP_SWI: begin
        alu_result[mem_addr_size-1:0] = addr_sum[mem_addr_size-1:0];
      end
      default: alu_result = '0;
    endcase
  end

endmodule

//--- cpu_asserts.sv
`timescale 1ns/100ps

module cpu_asserts (
  input logic clk,
  input logic rst,
  input logic host_gnt,
  input logic core_gnt,
  input logic host_rvalid,
  input logic core_rvalid,
  input logic mem_write,
  input logic core_req,
  input logic halted
);

  // a core request stays up until it is granted
  core_req_held: assert property (@(posedge clk) disable iff (rst)
    core_req && !core_gnt |=> core_req)
    else $error("core request dropped before its grant");

  host_read_data: assert property (@(posedge clk) disable iff (rst)
    host_gnt && !mem_write |=> host_rvalid)
    else $error("host read grant without rvalid one cycle later");

  core_read_data: assert property (@(posedge clk) disable iff (rst)
    core_gnt && !mem_write |=> core_rvalid)
    else $error("core read grant without rvalid one cycle later");

  no_req_halted: assert property (@(posedge clk) disable iff (rst)
    halted |=> halted && !core_req)
    else $error("core left halt or requested memory while halted");

endmodule

// arbiter and controller nets meet at the top level
bind cpu_top cpu_asserts chk0 (
  .clk, .rst, .host_gnt, .core_gnt, .host_rvalid, .core_rvalid, .mem_write, .core_req,
  .halted);

//--- cpu_pkg.sv
package cpu_pkg;

  localparam int data_size     = 32;
  localparam int reg_addr_size = 5;

  // ====================
  // opcodes
  // ====================

  typedef enum logic [5:0] {
    OP_LWI  = 6'b000010,
    OP_SWI  = 6'b001010,
    OP_ALU  = 6'b100000,
    OP_MOVI = 6'b100010,
    OP_ADDI = 6'b101000,
    OP_ORI  = 6'b101100,
    OP_HALT = 6'b111111
  } opcode_t;

  // shifts take the amount from rb
  typedef enum logic [4:0] {
    SUB_ADD  = 5'b00000,
    SUB_SUB  = 5'b00001,
    SUB_AND  = 5'b00010,
    SUB_XOR  = 5'b00011,
    SUB_OR   = 5'b00100,
    SUB_SLLI = 5'b01000,
    SUB_SRLI = 5'b01001
  } sub_op_t;

  // ====================
  // instruction formats
  // ====================

  // register type, rt is the destination
  typedef struct packed {
    logic       rsv;
    opcode_t    opcode;
    logic [4:0] rt;
    logic [4:0] ra;
    logic [4:0] rb;
    logic [4:0] unused;
    sub_op_t    sub_op;
  } instr_r_t;

  // immediate type, {ra, imm15} is the imm20 of movi
  typedef struct packed {
    logic        rsv;
    opcode_t     opcode;
    logic [4:0]  rt;
    logic [4:0]  ra;
    logic [14:0] imm15;
  } instr_i_t;

  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

  // memory request fields in order: en, write, addr, wdata
  // addr width comes from mem_addr_size in the module using it
  typedef logic [data_size-1:0] mem_data_t;

endpackage

//--- cpu_top.sv
`timescale 1ns/100ps

module cpu_top #(
  parameter int mem_addr_size = 10
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     system_enable,
  input  logic                     host_req,
  input  logic                     host_write,
  input  logic [mem_addr_size-1:0] host_addr,
  input  cpu_pkg::mem_data_t       host_wdata,
  output logic                     host_gnt,
  output logic                     host_rvalid,
  output cpu_pkg::mem_data_t       host_rdata,
  output logic                     mem_en,
  output logic                     mem_write,
  output logic [mem_addr_size-1:0] mem_addr,
  output cpu_pkg::mem_data_t       mem_wdata,
  input  cpu_pkg::mem_data_t       mem_rdata,
  output logic [63:0]              cycle_cnt,
  output logic [63:0]              ins_cnt,
  output logic                     halted
);
  import cpu_pkg::*;

  logic [mem_addr_size-1:0] pc;
  logic                     pc_inc;
  logic                     core_req;
  logic                     core_write;
  logic [mem_addr_size-1:0] core_addr;
  mem_data_t                core_wdata;
  logic                     core_gnt;
  logic                     core_rvalid;
  mem_data_t                core_rdata;
  opcode_t                  opcode;
  sub_op_t                  sub_op;
  logic [reg_addr_size-1:0] read_address1;
  logic [reg_addr_size-1:0] read_address2;
  logic [reg_addr_size-1:0] write_address;
  logic [data_size-1:0]     imm;
  logic                     imm_reg_select;
  logic                     reg_write;
  logic                     writeback_select;
  logic [data_size-1:0]     read_data1;
  logic [data_size-1:0]     read_data2;
  logic [data_size-1:0]     alu_result;

  pc_tick #(.mem_addr_size(mem_addr_size)) pc_tick1 (
    .clk(clk), .rst(rst), .pc_inc(pc_inc), .pc(pc), .cycle_cnt(cycle_cnt));

  ir_controller #(.mem_addr_size(mem_addr_size)) ir_controller1 (
    .clk(clk), .rst(rst), .system_enable(system_enable), .pc(pc), .pc_inc(pc_inc),
    .core_req(core_req), .core_write(core_write), .core_addr(core_addr),
    .core_wdata(core_wdata), .core_gnt(core_gnt), .core_rvalid(core_rvalid),
    .core_rdata(core_rdata), .opcode(opcode), .sub_op(sub_op),
    .read_address1(read_address1), .read_address2(read_address2),
    .write_address(write_address), .imm(imm), .imm_reg_select(imm_reg_select),
    .reg_write(reg_write), .writeback_select(writeback_select), .read_data2(read_data2),
    .alu_result(alu_result), .ins_cnt(ins_cnt), .halted(halted));

  // load data comes back through the arbiter's core side
  regfile regfile1 (
    .clk(clk), .rst(rst), .read_address1(read_address1), .read_address2(read_address2),
    .write_address(write_address), .reg_write(reg_write),
    .writeback_select(writeback_select), .alu_result(alu_result), .mem_data(core_rdata),
    .read_data1(read_data1), .read_data2(read_data2));

  alu32 #(.mem_addr_size(mem_addr_size)) alu1 (
    .opcode(opcode), .sub_op(sub_op), .read_data1(read_data1), .read_data2(read_data2),
    .imm(imm), .imm_reg_select(imm_reg_select), .alu_result(alu_result));

  mem_arbiter #(.mem_addr_size(mem_addr_size)) mem_arbiter1 (
    .clk(clk), .rst(rst), .host_req(host_req), .host_write(host_write),
    .host_addr(host_addr), .host_wdata(host_wdata), .host_gnt(host_gnt),
    .host_rvalid(host_rvalid), .host_rdata(host_rdata), .core_req(core_req),
    .core_write(core_write), .core_addr(core_addr), .core_wdata(core_wdata),
    .core_gnt(core_gnt), .core_rvalid(core_rvalid), .core_rdata(core_rdata),
    .mem_en(mem_en), .mem_write(mem_write), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_rdata(mem_rdata));

endmodule

//--- ir_controller.sv
`timescale 1ns/100ps

module ir_controller #(
  parameter int mem_addr_size = 10
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              system_enable,
  input  logic [mem_addr_size-1:0]          pc,
  output logic                              pc_inc,
  output logic                              core_req,
  output logic                              core_write,
  output logic [mem_addr_size-1:0]          core_addr,
  output logic [31:0]                       core_wdata,
  input  logic                              core_gnt,
  input  logic                              core_rvalid,
  input  logic [31:0]                       core_rdata,
  output cpu_pkg::opcode_t                  opcode,
  output cpu_pkg::sub_op_t                  sub_op,
  output logic [cpu_pkg::reg_addr_size-1:0] read_address1,
  output logic [cpu_pkg::reg_addr_size-1:0] read_address2,
  output logic [cpu_pkg::reg_addr_size-1:0] write_address,
  output logic [31:0]                       imm,
  output logic                              imm_reg_select,
  output logic                              reg_write,
  output logic                              writeback_select,
  input  logic [31:0]                       read_data2,
  input  logic [31:0]                       alu_result,
  output logic [63:0]                       ins_cnt,
  output logic                              halted
);
  import cpu_pkg::*;

  typedef enum logic [2:0] {
    idle, fetch, fetch_wait, execute, mem, mem_wait, writeback, halt
  } state_t;

  state_t      state;
  state_t      state_next;
  instr_u      ir_q;
  logic [19:0] imm20;
  logic        is_shift;
  logic        retire;

  // ====================
  // sequencing
  // ====================

  always_comb begin
    state_next = state;
    case (state)
      idle:       if (system_enable) state_next = fetch;
      fetch:      if (core_gnt) state_next = fetch_wait;
      fetch_wait: if (core_rvalid) state_next = execute;
      execute: begin
        case (opcode)
          OP_LWI, OP_SWI: state_next = mem;
          OP_HALT:        state_next = halt;
          default:        state_next = writeback;
        endcase
      end
      // stores finish on the grant, loads wait for data
      mem:        if (core_gnt) state_next = core_write ? writeback : mem_wait;
      mem_wait:   if (core_rvalid) state_next = writeback;
      writeback:  state_next = system_enable ? fetch : idle;
      halt:       state_next = halt;
      default:    state_next = idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= idle;
      ir_q    <= '0;
      ins_cnt <= '0;
    end else begin
      state <= state_next;
      if (state == fetch_wait && core_rvalid) begin
        ir_q <= core_rdata;
      end
      if (retire) begin
        ins_cnt <= ins_cnt + 64'd1;
      end
    end
  end

  assign retire = (state == writeback) || (state == execute && opcode == OP_HALT);
  assign pc_inc = (state == writeback);
  assign halted = (state == halt);

  // memory requests, held until granted
  assign core_req   = (state == fetch) || (state == mem);
  assign core_write = (state == mem) && (opcode == OP_SWI);
  assign core_addr  = (state == mem) ? alu_result[mem_addr_size-1:0] : pc;
  assign core_wdata = read_data2;

  // ====================
  // decode
  // ====================

  assign opcode        = ir_q.r.opcode;
  assign sub_op        = ir_q.r.sub_op;
  assign read_address1 = ir_q.r.ra;
  // swi reads rt as store data
  assign read_address2 = (opcode == OP_SWI) ? ir_q.i.rt : ir_q.r.rb;
  assign write_address = ir_q.i.rt;
  assign imm20         = {ir_q.i.ra, ir_q.i.imm15};

  assign is_shift = (opcode == OP_ALU) && (sub_op == SUB_SLLI || sub_op == SUB_SRLI);

  always_comb begin
    case (opcode)
      OP_ORI:  imm = {17'd0, ir_q.i.imm15};
      OP_MOVI: imm = {{12{imm20[19]}}, imm20};
      OP_ALU:  imm = {27'd0, ir_q.r.rb};
      default: imm = {{17{ir_q.i.imm15[14]}}, ir_q.i.imm15};
    endcase
  end

  assign imm_reg_select   = (opcode != OP_ALU) || is_shift;
  assign reg_write        = (state == writeback) && (opcode != OP_SWI);
  assign writeback_select = (opcode == OP_LWI);

endmodule

//--- mem_arbiter.sv
`timescale 1ns/100ps

module mem_arbiter #(
  parameter int mem_addr_size = 10
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     host_req,
  input  logic                     host_write,
  input  logic [mem_addr_size-1:0] host_addr,
  input  cpu_pkg::mem_data_t       host_wdata,
  output logic                     host_gnt,
  output logic                     host_rvalid,
  output cpu_pkg::mem_data_t       host_rdata,
  input  logic                     core_req,
  input  logic                     core_write,
  input  logic [mem_addr_size-1:0] core_addr,
  input  cpu_pkg::mem_data_t       core_wdata,
  output logic                     core_gnt,
  output logic                     core_rvalid,
  output cpu_pkg::mem_data_t       core_rdata,
  output logic                     mem_en,
  output logic                     mem_write,
  output logic [mem_addr_size-1:0] mem_addr,
  output cpu_pkg::mem_data_t       mem_wdata,
  input  cpu_pkg::mem_data_t       mem_rdata
);
  import cpu_pkg::*;

  typedef struct packed {
    logic                     en;
    logic                     write;
    logic [mem_addr_size-1:0] addr;
    mem_data_t                wdata;
  } mem_req_t;

  mem_req_t  host_r;
  mem_req_t  core_r;
  mem_req_t  mem_r;
  logic      rd_pend_q;
  logic      rd_host_q;
  mem_data_t host_hold;
  mem_data_t core_hold;

  assign host_r = '{en: host_req, write: host_write, addr: host_addr, wdata: host_wdata};
  assign core_r = '{en: core_req, write: core_write, addr: core_addr, wdata: core_wdata};

  // host always wins
  assign host_gnt = host_req;
  assign core_gnt = core_req && !host_req;
  assign mem_r    = host_req ? host_r : core_r;

  assign mem_en    = mem_r.en;
  assign mem_write = mem_r.write;
  assign mem_addr  = mem_r.addr;
  assign mem_wdata = mem_r.wdata;

  // owner of the read in flight
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_pend_q <= 1'b0;
      rd_host_q <= 1'b0;
    end else begin
      rd_pend_q <= mem_r.en && !mem_r.write;
      rd_host_q <= host_gnt;
    end
  end

  assign host_rvalid = rd_pend_q && rd_host_q;
  assign core_rvalid = rd_pend_q && !rd_host_q;

  // read data stays put until the owner's next read returns
  always_ff @(posedge clk) begin
    if (host_rvalid) host_hold <= mem_rdata;
    if (core_rvalid) core_hold <= mem_rdata;
  end

  assign host_rdata = host_rvalid ? mem_rdata : host_hold;
  assign core_rdata = core_rvalid ? mem_rdata : core_hold;

endmodule

//--- pc_tick.sv
`timescale 1ns/100ps

module pc_tick #(
  parameter int mem_addr_size = 10
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     pc_inc,
  output logic [mem_addr_size-1:0] pc,
  output logic [63:0]              cycle_cnt
);

  // instruction pointer, one word per instruction
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (pc_inc) begin
      pc <= pc + mem_addr_size'(1);
    end
  end

  // free running since reset
  always_ff @(posedge clk) begin
    if (rst) begin
      cycle_cnt <= '0;
    end else begin
      cycle_cnt <= cycle_cnt + 64'd1;
    end
  end

endmodule

//--- regfile.sv
`timescale 1ns/100ps

module regfile (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [cpu_pkg::reg_addr_size-1:0] read_address1,
  input  logic [cpu_pkg::reg_addr_size-1:0] read_address2,
  input  logic [cpu_pkg::reg_addr_size-1:0] write_address,
  input  logic                              reg_write,
  input  logic                              writeback_select,
  input  logic [cpu_pkg::data_size-1:0]     alu_result,
  input  logic [cpu_pkg::data_size-1:0]     mem_data,
  output logic [cpu_pkg::data_size-1:0]     read_data1,
  output logic [cpu_pkg::data_size-1:0]     read_data2
);
  import cpu_pkg::*;

  logic [data_size-1:0] regs [2**reg_addr_size];
  logic [data_size-1:0] write_data;

  // load data or alu result
  assign write_data = writeback_select ? mem_data : alu_result;

  // r0 is an ordinary register
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 2**reg_addr_size; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_write) begin
      regs[write_address] <= write_data;
    end
  end

  assign read_data1 = regs[read_address1];
  assign read_data2 = regs[read_address2];

endmodule

//--- tb_cpu.sv
`timescale 1ns/100ps

module tb_cpu;
  import cpu_pkg::*;

  localparam int res_base = 512;

  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] result;
  } row_t;

  logic        clk = 1'b0;
  logic        rst, system_enable, host_req, host_write;
  logic        host_gnt, host_rvalid, mem_en, mem_write, halted;
  logic [9:0]  host_addr, mem_addr;
  mem_data_t   host_wdata, host_rdata, mem_wdata;
  mem_data_t   mem_rdata = '0;
  logic [63:0] cycle_cnt, ins_cnt;
  logic [63:0] last_cycle_cnt = '0;
  logic        prev_rst = 1'b1;
  int          cycles = 0;
  int          limit = 100000;

  logic [31:0] mem [1024];
  logic [31:0] model_mem [1024];
  logic [31:0] model_regs [32];
  row_t        rows[$];
  string       names[$];
  logic [31:0] prog[$];

  cpu_top #(.mem_addr_size(10)) dut0 (.*);

  always #20 clk = ~clk;

  // synchronous word memory, fill pattern loaded during reset
  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 1024; i++) begin
        mem[i] <= 32'hc0de_0000 | 32'(i);
      end
    end else if (mem_en) begin
      if (mem_write) mem[mem_addr] <= mem_wdata;
      else mem_rdata <= mem[mem_addr];
    end
  end

  always @(negedge clk) begin
    cycles++;
    if (cycles > limit) stop_run("timeout, the core did not halt within the cycle limit");
    if (halted && mem_en && mem_write) stop_run("memory write seen after halt");
    // one count per clock once out of reset
    if (!prev_rst) check_value("cycle_cnt_step", last_cycle_cnt + 64'd1, cycle_cnt);
    prev_rst       = rst;
    last_cycle_cnt = cycle_cnt;
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      stop_run($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
    end
  endtask

  // called at a falling edge, returns at a falling edge
  task automatic host_access(input logic wr, input logic [9:0] addr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
    host_req   = 1'b1;
    host_write = wr;
    host_addr  = addr;
    host_wdata = wdata;
    @(posedge clk);
    while (!host_gnt) @(posedge clk);
    @(negedge clk);
    host_req = 1'b0;
    rdata    = '0;
    if (!wr) begin
      while (!host_rvalid) @(negedge clk);
      rdata = host_rdata;
    end
  endtask

  // ====================
  // reference model
  // ====================

  function automatic logic [31:0] enc_r(sub_op_t sub, logic [4:0] rt, logic [4:0] ra,
                                        logic [4:0] rb);
    return {1'b0, OP_ALU, rt, ra, rb, 5'd0, sub};
  endfunction

  function automatic logic [31:0] enc_i(opcode_t op, logic [4:0] rt, logic [4:0] ra,
                                        logic [14:0] imm);
    return {1'b0, op, rt, ra, imm};
  endfunction

  task automatic model_exec(input logic [31:0] w);
    logic [31:0] a, b, simm, res;
    logic [9:0]  ea;
    a    = model_regs[w[19:15]];
    b    = model_regs[w[14:10]];
    simm = {{17{w[14]}}, w[14:0]};
    ea   = 10'(a + simm);
    res  = model_regs[w[24:20]];
    case (w[30:25])
      OP_ALU: begin
        case (w[4:0])
          SUB_ADD:  res = a + b;
          SUB_SUB:  res = a - b;
          SUB_AND:  res = a & b;
          SUB_OR:   res = a | b;
          SUB_XOR:  res = a ^ b;
          SUB_SLLI: res = a << w[14:10];
          SUB_SRLI: res = a >> w[14:10];
          default:  res = 32'd0;
        endcase
      end
      OP_ADDI: res = a + simm;
      OP_ORI:  res = a | {17'd0, w[14:0]};
      OP_MOVI: res = {{12{w[19]}}, w[19:0]};
      OP_LWI:  res = model_mem[ea];
      OP_SWI:  model_mem[ea] = res;
      default: ;
    endcase
    model_regs[w[24:20]] = res;
  endtask

  // each row is followed by a store of its destination into the result area
  task automatic add_row(input string name, input logic [31:0] instr);
    logic [31:0] store;
    row_t        row;
    store = {1'b0, OP_SWI, instr[24:20], 5'd0, 15'(res_base + rows.size())};
    model_exec(instr);
    row.instr  = instr;
    row.result = model_regs[instr[24:20]];
    rows.push_back(row);
    names.push_back(name);
    model_exec(store);
    prog.push_back(instr);
    prog.push_back(store);
  endtask

  // movi the upper 20 bits, shift left 12, then or in the low 12
  task automatic load_reg(input logic [4:0] rd, input logic [31:0] v);
    add_row($sformatf("movi_r%0d", rd), enc_i(OP_MOVI, rd, v[31:27], v[26:12]));
    add_row($sformatf("slli_r%0d", rd), enc_r(SUB_SLLI, rd, rd, 5'd12));
    add_row($sformatf("ori_r%0d", rd), enc_i(OP_ORI, rd, rd, {3'd0, v[11:0]}));
  endtask

  // ====================
  // stimulus
  // ====================

  initial begin
    logic [31:0] r, rd;
    int          xor_slot, pick;
    void'($urandom(97));
    rst           = 1'b1;
    system_enable = 1'b0;
    host_req      = 1'b0;
    host_write    = 1'b0;
    host_addr     = '0;
    host_wdata    = '0;
    for (int i = 0; i < 1024; i++) model_mem[i] = 32'hc0de_0000 | 32'(i);
    for (int i = 0; i < 32; i++) model_regs[i] = '0;

    load_reg(5'd1, $urandom);
    load_reg(5'd2, $urandom);
    add_row("add", enc_r(SUB_ADD, 5'd3, 5'd1, 5'd2));
    add_row("sub", enc_r(SUB_SUB, 5'd4, 5'd1, 5'd2));
    add_row("and", enc_r(SUB_AND, 5'd5, 5'd1, 5'd2));
    add_row("or", enc_r(SUB_OR, 5'd6, 5'd1, 5'd2));
    xor_slot = rows.size();
    add_row("xor", enc_r(SUB_XOR, 5'd7, 5'd1, 5'd2));
    r = $urandom;
    add_row("slli", enc_r(SUB_SLLI, 5'd8, 5'd1, r[4:0]));
    add_row("srli", enc_r(SUB_SRLI, 5'd9, 5'd2, r[9:5]));
    add_row("addi_neg", enc_i(OP_ADDI, 5'd10, 5'd1, {1'b1, r[23:10]}));
    add_row("addi_pos", enc_i(OP_ADDI, 5'd11, 5'd2, {1'b0, r[31:18]}));
    r = $urandom;
    add_row("ori_zext", enc_i(OP_ORI, 5'd12, 5'd0, {1'b1, r[13:0]}));
    add_row("movi_neg", enc_i(OP_MOVI, 5'd13, {1'b1, r[17:14]}, r[31:17]));
    add_row("movi_pos", enc_i(OP_MOVI, 5'd14, {1'b0, r[3:0]}, r[18:4]));
    add_row("srli_neg", enc_r(SUB_SRLI, 5'd15, 5'd13, 5'd7));
    add_row("lwi_reload", enc_i(OP_LWI, 5'd16, 5'd0, 15'(res_base + xor_slot)));
    prog.push_back({1'b0, OP_HALT, 25'd0});
    limit = 12 * prog.size() + 200;

    repeat (10) @(negedge clk);
    rst = 1'b0;

    // load and read back with the core held idle
    for (int i = 0; i < prog.size(); i++) host_access(1'b1, 10'(i), prog[i], rd);
    for (int i = 0; i < prog.size(); i++) begin
      host_access(1'b0, 10'(i), '0, rd);
      check_value($sformatf("readback_%0d", i), 64'(prog[i]), 64'(rd));
    end
    check_value("ins_cnt_idle", 64'd0, ins_cnt);

    // background host reads stall the core while it runs
    system_enable = 1'b1;
    while (!halted) begin
      if ($urandom % 4 == 0) begin
        pick = $urandom % prog.size();
        host_access(1'b0, 10'(pick), '0, rd);
        check_value("host_read_during_run", 64'(prog[pick]), 64'(rd));
      end else begin
        @(negedge clk);
      end
    end

    check_value("ins_cnt_at_halt", 64'(prog.size()), ins_cnt);
    foreach (rows[k]) begin
      host_access(1'b0, 10'(res_base + k), '0, rd);
      check_value($sformatf("%s_%h", names[k], rows[k].instr), 64'(rows[k].result),
                  64'(rd));
    end
    check_value("ins_cnt_after_halt", 64'(prog.size()), ins_cnt);
    check_value("halted_after_halt", 64'd1, 64'(halted));
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- verilog.f
cpu_pkg.sv
pc_tick.sv
ir_controller.sv
regfile.sv
alu32.sv
mem_arbiter.sv
cpu_top.sv
cpu_asserts.sv
tb_cpu.sv
